//--- src/alien_pkg.sv
`default_nettype none

package alien_pkg;

    // Screen coordinates
    localparam int COORD_W = 12;

    // Row of sprites, 16x16 each, origins 20 columns apart
    localparam int alien_count = 5;
    localparam int SLOT_W = $clog2(alien_count);
    localparam int SPRITE_SIZE = 16;
    localparam int SLOT_PITCH = 20;

    // Pixel intensity
    localparam int PIX_W = 4;
    localparam logic [PIX_W-1:0] PIX_ON = '1;

    // Formation origin out of reset, just above the first sprite pixel
    localparam int START_ROW = 20;
    localparam int START_COL = 312;

    // Step sizes and turn points
    localparam int STEP_COLS = 12;
    localparam int DROP_ROWS = 24;
    localparam int LEFT_LIMIT = 21;
    localparam int RIGHT_LIMIT = 560;
    localparam int BOTTOM_LIMIT = 440;

    // Off-screen resting place once landed
    localparam int PARK_ROW = 480;
    localparam int PARK_COL = 640;

    typedef struct packed {
        logic [COORD_W-1:0] row;
        logic [COORD_W-1:0] col;
    } screen_pos_t;

    // Bit k of active belongs to alien k
    typedef struct packed {
        logic [alien_count-1:0] active;
        logic [PIX_W-1:0]       pix;
    } alien_hit_t;

endpackage

`default_nettype wire

//--- src/alien_glyph_rom.sv
`timescale 1ns/1ps
`default_nettype none

module alien_glyph_rom
    import alien_pkg::*;
(
    input  logic [3:0] glyph_row,
    input  logic [3:0] glyph_col,
    output logic       glyph_lit
);

    // One mask per pair of rows, bit c is column c of the sprite
    logic [SPRITE_SIZE-1:0] row_mask;

    always_comb
    begin
        case (glyph_row[3:1])
            // Head tip
            3'd0:
            begin
                row_mask = 16'h03C0;
            end
            3'd1:
            begin
                row_mask = 16'h0FF0;
            end
            3'd2:
            begin
                row_mask = 16'h3FFC;
            end
            // Eyes cut out of the body
            3'd3:
            begin
                row_mask = 16'hF3CF;
            end
            3'd4:
            begin
                row_mask = 16'hFFFF;
            end
            // Legs
            3'd5:
            begin
                row_mask = 16'h0C30;
            end
            3'd6:
            begin
                row_mask = 16'h33CC;
            end
            default:
            begin
                row_mask = 16'hCC33;
            end
        endcase
    end

    assign glyph_lit = row_mask[glyph_col];

endmodule

`default_nettype wire

//--- src/formation_renderer.sv
`timescale 1ns/1ps
`default_nettype none

module formation_renderer
    import alien_pkg::*;
(
    input  screen_pos_t scan_pos,
    input  screen_pos_t origin,
    output alien_hit_t  hit
);

    logic [COORD_W-1:0] row_off;
    logic [COORD_W-1:0] col_off;
    logic [COORD_W-1:0] slot_col;
    logic [SLOT_W-1:0]  slot;
    logic               row_hit;
    logic               col_hit;
    logic               slot_hit;
    logic [3:0]         glyph_row;
    logic [3:0]         glyph_col;
    logic               glyph_lit;

    // Offsets counted from the first sprite pixel at origin plus one
    assign row_off = scan_pos.row - origin.row - COORD_W'(1);
    assign col_off = scan_pos.col - origin.col - COORD_W'(1);

    assign row_hit = (scan_pos.row > origin.row) && (row_off < COORD_W'(SPRITE_SIZE));
    assign col_hit = (scan_pos.col > origin.col)
                  && (col_off < COORD_W'(alien_count * SLOT_PITCH));

    // Slot index and the column inside that slot
    assign slot     = SLOT_W'(col_off / COORD_W'(SLOT_PITCH));
    assign slot_col = col_off - COORD_W'(slot) * COORD_W'(SLOT_PITCH);

    // Last four columns of each pitch are the gap between aliens
    assign slot_hit = row_hit && col_hit && (slot_col < COORD_W'(SPRITE_SIZE));

    assign glyph_row = row_off[3:0];
    assign glyph_col = slot_col[3:0];

    alien_glyph_rom u_glyph (
        .glyph_row (glyph_row),
        .glyph_col (glyph_col),
        .glyph_lit (glyph_lit)
    );

    always_comb
    begin
        hit.active = '0;
        if (slot_hit)
        begin
            hit.active[slot] = 1'b1;
        end
        hit.pix = (slot_hit && glyph_lit) ? PIX_ON : '0;
    end

endmodule

`default_nettype wire

//--- src/formation_motion.sv
`timescale 1ns/1ps
`default_nettype none

module formation_motion
    import alien_pkg::*;
#(
    parameter int STEP_CYCLES = 16_000_000
)
(
    input  logic        clk,
    input  logic        arst_n,
    output screen_pos_t origin,
    output logic        landed
);

    localparam int CNT_W = (STEP_CYCLES > 1) ? $clog2(STEP_CYCLES) : 1;

    logic [CNT_W-1:0]   step_cnt;
    logic               step;
    logic               move_left;
    logic               drop;
    logic [COORD_W-1:0] drop_row;
    screen_pos_t        origin_next;
    logic               move_left_next;
    logic               landed_next;

    // Step on the last cycle of each period
    assign step = (step_cnt == CNT_W'(STEP_CYCLES - 1));

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            step_cnt <= '0;
        end
        else if (step)
        begin
            step_cnt <= '0;
        end
        else
        begin
            step_cnt <= step_cnt + CNT_W'(1);
        end
    end

    // Turn around once the edge column is passed
    assign drop = move_left ? (origin.col < COORD_W'(LEFT_LIMIT))
                            : (origin.col > COORD_W'(RIGHT_LIMIT));
    assign drop_row = origin.row + COORD_W'(DROP_ROWS);

    always_comb
    begin
        origin_next    = origin;
        move_left_next = move_left;
        landed_next    = landed;
        if (!landed)
        begin
            if (drop)
            begin
                if (drop_row > COORD_W'(BOTTOM_LIMIT))
                begin
                    // Reached the bottom, park off screen for good
                    origin_next.row = COORD_W'(PARK_ROW);
                    origin_next.col = COORD_W'(PARK_COL);
                    landed_next     = 1'b1;
                end
                else
                begin
                    origin_next.row = drop_row;
                    move_left_next  = !move_left;
                end
            end
            else if (move_left)
            begin
                origin_next.col = origin.col - COORD_W'(STEP_COLS);
            end
            else
            begin
                origin_next.col = origin.col + COORD_W'(STEP_COLS);
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            origin.row <= COORD_W'(START_ROW);
            origin.col <= COORD_W'(START_COL);
            move_left  <= 1'b0;
            landed     <= 1'b0;
        end
        else if (step)
        begin
            origin     <= origin_next;
            move_left  <= move_left_next;
            landed     <= landed_next;
        end
    end

    // One step past the right limit is the furthest the row can go
    a_col_bound: assert property (
        @(posedge clk) disable iff (!arst_n)
        !landed |-> (origin.col <= COORD_W'(RIGHT_LIMIT + STEP_COLS))
    );

    // landed is sticky until reset
    a_landed_sticky: assert property (
        @(posedge clk) disable iff (!arst_n)
        landed |=> landed
    );

endmodule

`default_nettype wire

//--- src/alien_formation.sv
`timescale 1ns/1ps
`default_nettype none

module alien_formation
    import alien_pkg::*;
#(
    parameter int STEP_CYCLES = 16_000_000
)
(
    input  logic        clk,
    input  logic        arst_n,
    input  screen_pos_t scan_pos,
    output alien_hit_t  hit,
    output logic        landed
);

    // Current top-left corner of the formation
    screen_pos_t origin;

    formation_motion #(
        .STEP_CYCLES (STEP_CYCLES)
    ) u_motion (
        .clk    (clk),
        .arst_n (arst_n),
        .origin (origin),
        .landed (landed)
    );

    // Pure lookup against the scan position, no pipeline
    formation_renderer u_renderer (
        .scan_pos (scan_pos),
        .origin   (origin),
        .hit      (hit)
    );

endmodule

`default_nettype wire

//--- testbench/tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD_NS        = 8,
    parameter int RESET_CYCLES     = 10,
    parameter int RELEASE_DELAY_NS = 1
)
(
    output logic clk,
    output logic arst_n
);

    initial
    begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // Release lands just after an edge, like every other DUT input
    initial
    begin
        arst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #(RELEASE_DELAY_NS);
        arst_n = 1'b1;
    end

endmodule

`default_nettype wire

//--- testbench/tb_alien_formation.sv
`timescale 1ns/1ps
`default_nettype none

module tb_alien_formation
    import alien_pkg::*;
();

    localparam int STEP_CYCLES    = 4;
    localparam int CLK_PERIOD     = 8;
    localparam int RESET_CYCLES   = 10;
    localparam int DRIVE_DELAY    = 1;
    localparam int SAMPLE_DELAY   = CLK_PERIOD - DRIVE_DELAY - 1;
    localparam int TIMEOUT_MARGIN = 200;
    localparam int SCREEN_ROWS    = 480;
    localparam int SCREEN_COLS    = 640;
    localparam string TRACE_FILE  = "testbench/alien_trace.txt";

    logic        clk;
    logic        arst_n;
    screen_pos_t scan_pos;
    alien_hit_t  hit;
    logic        landed;

    // One entry per probe line of the trace
    int tr_cycle[$];
    int tr_row[$];
    int tr_col[$];
    int tr_mask[$];
    int tr_pix[$];
    int tr_landed[$];

    // Reference copy of the formation state
    int model_row;
    int model_col;
    bit model_left;
    bit model_landed;

    int errors      = 0;
    int edge_cnt    = 0;
    int cycle_limit = 0;
    bit trace_ready = 1'b0;

    tb_clock_gen #(
        .PERIOD_NS        (CLK_PERIOD),
        .RESET_CYCLES     (RESET_CYCLES),
        .RELEASE_DELAY_NS (DRIVE_DELAY)
    ) u_clock_gen (
        .clk    (clk),
        .arst_n (arst_n)
    );

    alien_formation #(
        .STEP_CYCLES (STEP_CYCLES)
    ) u_alien_formation (
        .clk      (clk),
        .arst_n   (arst_n),
        .scan_pos (scan_pos),
        .hit      (hit),
        .landed   (landed)
    );

    task automatic stop_with_failure();
        $display("*** TEST FAILED ***");
        $fatal(1, "simulation stopped on the first failure");
    endtask

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected)
        begin
            errors++;
            $display("** Error at time %0t: %s is %0h, expected %0h",
                     $time, what, actual, expected);
            stop_with_failure();
        end
    endtask

    task automatic load_trace();
        int    fd;
        int    line_no;
        int    fields;
        int    cyc;
        int    row;
        int    col;
        int    mask;
        int    pix;
        int    lnd;
        string line;
        string problem;
        problem = "";
        line_no = 0;
        fd = $fopen(TRACE_FILE, "r");
        if (fd == 0)
        begin
            $display("Could not open the trace file %s", TRACE_FILE);
            stop_with_failure();
        end
        else
        begin
            while (problem.len() == 0 && $fgets(line, fd) != 0)
            begin
                line_no++;
                // Comment and blank lines carry no probe
                if (line.len() > 1 && line.substr(0, 0) != "#")
                begin
                    fields = $sscanf(line, "%d %d %d %h %h %d", cyc, row, col, mask, pix, lnd);
                    if (fields != 6)
                    begin
                        problem = $sformatf("line %0d does not hold six fields", line_no);
                    end
                    else if (tr_cycle.size() > 0 && cyc <= tr_cycle[$])
                    begin
                        problem = $sformatf("line %0d is not in rising cycle order", line_no);
                    end
                    else
                    begin
                        tr_cycle.push_back(cyc);
                        tr_row.push_back(row);
                        tr_col.push_back(col);
                        tr_mask.push_back(mask);
                        tr_pix.push_back(pix);
                        tr_landed.push_back(lnd);
                    end
                end
            end
            $fclose(fd);
            if (problem.len() != 0)
            begin
                $display("The trace file %s is malformed, %s", TRACE_FILE, problem);
                stop_with_failure();
            end
            else if (tr_cycle.size() == 0)
            begin
                $display("The trace file %s holds no probe lines", TRACE_FILE);
                stop_with_failure();
            end
        end
    endtask

    // Lit columns for each pair of sprite rows
    function automatic bit glyph_pixel(input int r, input int c);
        case (r / 2)
            0: return (c >= 6 && c <= 9);
            1: return (c >= 4 && c <= 11);
            2: return (c >= 2 && c <= 13);
            3: return (c <= 3) || (c >= 6 && c <= 9) || (c >= 12);
            4: return 1'b1;
            5: return (c == 4) || (c == 5) || (c == 10) || (c == 11);
            6: return (c == 2) || (c == 3) || (c >= 6 && c <= 9) || (c == 12) || (c == 13);
            default: return (c <= 1) || (c == 4) || (c == 5) || (c == 10) || (c == 11)
                         || (c >= 14);
        endcase
    endfunction

    function automatic alien_hit_t expected_hit(input int row, input int col,
                                                input int org_row, input int org_col);
        alien_hit_t result;
        int         dr;
        int         dc;
        int         slot;
        int         c;
        result = '0;
        dr = row - org_row - 1;
        dc = col - org_col - 1;
        if (dr >= 0 && dr < SPRITE_SIZE && dc >= 0 && dc < alien_count * SLOT_PITCH)
        begin
            slot = dc / SLOT_PITCH;
            c = dc % SLOT_PITCH;
            // Columns 16 to 19 of a pitch are the gap
            if (c < SPRITE_SIZE)
            begin
                result.active = alien_count'(1 << slot);
                result.pix = glyph_pixel(dr, c) ? PIX_ON : '0;
            end
        end
        return result;
    endfunction

    // One formation step, applied on every STEP_CYCLES-th edge
    task automatic advance_model();
        if (!model_landed)
        begin
            if ((model_left && model_col < LEFT_LIMIT) || (!model_left && model_col > RIGHT_LIMIT))
            begin
                if (model_row + DROP_ROWS > BOTTOM_LIMIT)
                begin
                    model_row = PARK_ROW;
                    model_col = PARK_COL;
                    model_landed = 1'b1;
                end
                else
                begin
                    model_row = model_row + DROP_ROWS;
                    model_left = !model_left;
                end
            end
            else if (model_left)
            begin
                model_col = model_col - STEP_COLS;
            end
            else
            begin
                model_col = model_col + STEP_COLS;
            end
        end
    endtask

    task automatic pick_random_probe(output int row, output int col);
        if (!model_landed && ($urandom % 2) == 0)
        begin
            // Close to the formation so that most probes touch a sprite
            row = model_row + int'($urandom % (SPRITE_SIZE + 4));
            col = model_col + int'($urandom % (alien_count * SLOT_PITCH + 4));
        end
        else
        begin
            row = int'($urandom % SCREEN_ROWS);
            col = int'($urandom % SCREEN_COLS);
        end
    endtask

    task automatic check_outputs(input int cyc, input alien_hit_t exp_hit, input logic exp_landed);
        string where;
        where = $sformatf("cycle %0d, scan row %0d col %0d", cyc, scan_pos.row, scan_pos.col);
        check_value(32'(hit.active), 32'(exp_hit.active), {"active mask at ", where});
        check_value(32'(hit.pix), 32'(exp_hit.pix), {"intensity at ", where});
        check_value(32'(landed), 32'(exp_landed), {"landed at ", where});
    endtask

    // Bounds the run by the last trace cycle plus a margin
    always @(posedge clk)
    begin
        edge_cnt <= edge_cnt + 1;
        if (trace_ready && edge_cnt > cycle_limit)
        begin
            $display("Timeout, the run went past %0d clock cycles", cycle_limit);
            stop_with_failure();
        end
    end

    initial
    begin
        int         cyc;
        int         idx;
        int         row;
        int         col;
        alien_hit_t exp_hit;
        logic       exp_landed;
        void'($urandom(53));
        scan_pos = '0;
        load_trace();
        cycle_limit = tr_cycle[$] + TIMEOUT_MARGIN;
        trace_ready = 1'b1;
        model_row = START_ROW;
        model_col = START_COL;
        model_left = 1'b0;
        model_landed = 1'b0;

        wait (arst_n === 1'b1);
        cyc = 0;
        idx = 0;
        while (cyc <= tr_cycle[$])
        begin
            if (idx < tr_cycle.size() && tr_cycle[idx] == cyc)
            begin
                row = tr_row[idx];
                col = tr_col[idx];
                exp_hit.active = alien_count'(tr_mask[idx]);
                exp_hit.pix = PIX_W'(tr_pix[idx]);
                exp_landed = (tr_landed[idx] != 0);
                idx++;
            end
            else
            begin
                pick_random_probe(row, col);
                exp_hit = expected_hit(row, col, model_row, model_col);
                exp_landed = model_landed;
            end
            scan_pos.row = COORD_W'(row);
            scan_pos.col = COORD_W'(col);
            #(SAMPLE_DELAY);
            check_outputs(cyc, exp_hit, exp_landed);
            @(posedge clk);
            #(DRIVE_DELAY);
            cyc++;
            if (cyc % STEP_CYCLES == 0)
            begin
                advance_model();
            end
        end

        if (errors == 0)
        begin
            $display("*** TEST PASSED ***");
            $finish;
        end
        else
        begin
            $display("*** TEST FAILED ***");
            $fatal(1, "%0d checks failed", errors);
        end
    end

endmodule

`default_nettype wire

//--- testbench/alien_trace.txt
# cycle row col mask pix landed
# cycle counts rising edges after reset release, mask and pix are hex
# Alien 0 row pairs right after reset
0 21 320 01 f 0
1 24 317 01 f 0
2 25 314 01 0 0
3 28 318 01 0 0
4 29 340 01 f 0
5 31 335 01 f 0
6 34 331 01 f 0
7 36 327 01 0 0
# Gaps, row band edges and the five slots
8 29 353 00 0 0
9 20 345 00 0 0
10 37 345 00 0 0
11 29 357 02 f 0
12 29 392 04 f 0
13 29 424 08 f 0
14 29 437 10 f 0
15 29 445 00 0 0
16 29 439 00 0 0
17 29 360 00 0 0
18 36 456 10 f 0
19 27 405 04 0 0
# Alien 0 moving right by 12 columns per step
20 29 373 01 f 0
21 29 361 00 0 0
24 29 385 01 f 0
28 29 397 01 f 0
32 29 409 01 f 0
35 29 409 01 f 0
36 29 409 00 0 0
37 29 421 01 f 0
# Drop at the right limit, then left
84 29 565 01 f 0
88 53 565 01 f 0
89 29 565 00 0 0
92 53 553 01 f 0
# Drop at the left limit, then right
272 53 13 01 f 0
276 77 13 01 f 0
277 53 13 00 0 0
280 77 25 01 f 0
# Last pass before the bottom
3280 437 13 01 f 0
3283 437 13 01 f 0
# Parked off screen with landed set
3284 437 13 00 0 1
3285 479 639 00 0 1
3290 437 25 00 0 1
3300 0 0 00 0 1
3310 100 400 00 0 1
3320 240 320 00 0 1

//--- files.f
src/alien_pkg.sv
src/alien_glyph_rom.sv
src/formation_renderer.sv
src/formation_motion.sv
src/alien_formation.sv
testbench/tb_clock_gen.sv
testbench/tb_alien_formation.sv

//--- Makefile
# Verilator build and run for the alien formation testbench
VERILATOR ?= verilator
TOP       ?= tb_alien_formation
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
